//--- sources.f
+incdir+logic
logic/video_types_pkg.sv
logic/host_bus_pkg.sv
logic/tile_step_if.sv
logic/tile_fetcher.sv
logic/plane_shifter.sv
logic/pixel_mixer.sv
logic/tile_video_top.sv
testbench/tb_clock_gen.sv
testbench/tile_video_asserts.sv
testbench/tb_tile_video.sv

//--- Bender.yml
package:
  name: tile_video

sources:
  - include_dirs:
      - logic
    files:
      - logic/video_types_pkg.sv
      - logic/host_bus_pkg.sv
      - logic/tile_step_if.sv
      - logic/tile_fetcher.sv
      - logic/plane_shifter.sv
      - logic/pixel_mixer.sv
      - logic/tile_video_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tile_video_asserts.sv
      - testbench/tb_tile_video.sv

//--- testbench/tb_tile_video.sv
`timescale 1ns/10ps
`include "tile_video_macros.svh"

module tb_tile_video;

	localparam int wait_limit = 20000;
	localparam int line_pixels = `TV_TILE_COLS * `TV_PIX_PER_TILE;

	logic CLK_24M;
	logic I_H_CNT;

	// DUT inputs start at a known value
	host_bus_pkg::cpu_addr_t cpu_addr = '0;
	logic [7:0]  cpu_wdata = '0;
	logic        cpu_we = 1'b0;
	logic        cpu_re = 1'b0;
	logic [15:0] dl_addr = '0;
	logic        dl_wr = 1'b0;
	logic [7:0]  dl_data = '0;
	logic        render_start = 1'b0;
	logic [7:0]  render_line = '0;
	logic        flip = 1'b0;
	logic        credit_return = 1'b0;

	// DUT outputs
	logic [7:0]  cpu_rdata;
	logic        busy;
	logic        pix_valid;
	logic [3:0]  pix_color;
	logic [1:0]  pix_value;
	logic        line_done;

	// Mirrors of everything the loader and CPU wrote
	logic [7:0] tile_mirror [`TV_TILE_RAM_WORDS];
	logic [7:0] plane0_mirror [`TV_PLANE_ROM_WORDS];
	logic [7:0] plane1_mirror [`TV_PLANE_ROM_WORDS];
	logic [3:0] color_mirror [`TV_COLOR_WORDS];

	// Line being checked by the monitor
	logic [7:0] exp_line = '0;
	logic       exp_flip = 1'b0;
	int         pix_idx = 0;
	int         done_cnt = 0;
	video_types_pkg::tile_pixel_t exp_pix;

	// Credit bookkeeping
	int   pix_rcvd = 0;
	int   credits_ret = 0;
	logic stall_en = 1'b0;
	int   stall_left = 0;

	// Run status
	int   err_cnt = 0;
	int   pass_cnt = 0;
	int   fail_cnt = 0;
	logic timed_out = 1'b0;
	logic [7:0] test_line;

	tb_clock_gen u_clk (
		.CLK_24M (CLK_24M),
		.I_H_CNT (I_H_CNT)
	);

	tile_video_top u_dut (
		.CLK_24M       (CLK_24M),
		.I_H_CNT       (I_H_CNT),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_we        (cpu_we),
		.cpu_re        (cpu_re),
		.cpu_rdata     (cpu_rdata),
		.dl_addr       (dl_addr),
		.dl_wr         (dl_wr),
		.dl_data       (dl_data),
		.render_start  (render_start),
		.render_line   (render_line),
		.flip          (flip),
		.busy          (busy),
		.credit_return (credit_return),
		.pix_valid     (pix_valid),
		.pix_color     (pix_color),
		.pix_value     (pix_value),
		.line_done     (line_done)
	);

	// ------------------------------
	// Reference model
	// ------------------------------

	// Expected pixel n of a line from the mirrors
	function automatic video_types_pkg::tile_pixel_t ref_pixel(
		input logic [7:0] line,
		input int         n,
		input logic       flp
	);
		video_types_pkg::tile_pixel_t px;
		int          x;
		int          col;
		int          bit_sel;
		logic [7:0]  code;
		logic [10:0] row_addr;
		// Mirrored line reads the source from the right edge
		x = flp ? (line_pixels - 1 - n) : n;
		col = x / `TV_PIX_PER_TILE;
		bit_sel = 7 - (x % `TV_PIX_PER_TILE);
		code = tile_mirror[(line / 8) * `TV_TILE_COLS + col];
		row_addr = {code, line[2:0]};
		px.value = {plane1_mirror[row_addr][bit_sel], plane0_mirror[row_addr][bit_sel]};
		// Group of four tile rows joined with the column
		px.color = color_mirror[(line / 32) * `TV_TILE_COLS + col];
		return px;
	endfunction

	task automatic report_error(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	// Errors from the checks here and from the bound assertions
	function automatic int error_total();
		return err_cnt + u_dut.u_asserts.assert_errs;
	endfunction

	// ------------------------------
	// Pixel monitor at mid-cycle
	// ------------------------------

	always @(negedge CLK_24M) begin
		if (pix_valid) begin
			pix_rcvd++;
			if (pix_idx >= line_pixels) begin
				report_error("pixel arrived after the end of the line");
			end else begin
				exp_pix = ref_pixel(exp_line, pix_idx, exp_flip);
				if ((pix_color !== exp_pix.color) || (pix_value !== exp_pix.value)) begin
					report_error($sformatf("line %0d flip %0b pixel %0d got %h/%0d, expected %h/%0d",
						exp_line, exp_flip, pix_idx, pix_color, pix_value,
						exp_pix.color, exp_pix.value));
				end
			end
			pix_idx++;
		end
		// Consumer side never holds more than the credit depth
		if (pix_rcvd - credits_ret > `TV_CREDITS) begin
			report_error($sformatf("%0d unreturned pixels", pix_rcvd - credits_ret));
		end
		if (line_done) begin
			done_cnt++;
			if (busy) begin
				report_error("busy still high during line_done");
			end
			if (pix_idx != line_pixels) begin
				report_error($sformatf("line_done after %0d pixels", pix_idx));
			end
		end
	end

	// Credit return pauses for random stretches when stalls are on
	always @(posedge CLK_24M) begin
		if (!I_H_CNT) begin
			credit_return <= 1'b0;
		end else if (stall_left > 0) begin
			stall_left--;
			credit_return <= 1'b0;
		end else if (stall_en && ($urandom % 8 == 0)) begin
			stall_left = 4 + int'($urandom % 24);
			credit_return <= 1'b0;
		end else if (pix_rcvd > credits_ret) begin
			credit_return <= 1'b1;
			credits_ret++;
		end else begin
			credit_return <= 1'b0;
		end
	end

	// ------------------------------
	// Port drivers
	// ------------------------------

	task automatic cpu_write(input host_bus_pkg::cpu_addr_t addr, input logic [7:0] data);
		@(posedge CLK_24M);
		cpu_we    <= 1'b1;
		cpu_addr  <= addr;
		cpu_wdata <= data;
		@(posedge CLK_24M);
		cpu_we    <= 1'b0;
	endtask

	// Data shows one cycle after the strobe
	task automatic cpu_read(input host_bus_pkg::cpu_addr_t addr, output logic [7:0] data);
		@(posedge CLK_24M);
		cpu_re   <= 1'b1;
		cpu_addr <= addr;
		@(posedge CLK_24M);
		cpu_re   <= 1'b0;
		@(negedge CLK_24M);
		data = cpu_rdata;
	endtask

	task automatic write_loader(input logic [15:0] addr, input logic [7:0] data);
		@(posedge CLK_24M);
		dl_wr   <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
	endtask

	// Random contents for both planes, the color table and the tile RAM
	task automatic fill_memories();
		logic [7:0] data;
		for (int i = 0; i < `TV_PLANE_ROM_WORDS; i++) begin
			plane0_mirror[i] = 8'($urandom);
			plane1_mirror[i] = 8'($urandom);
			write_loader({`TV_REGION_PLANE0, 1'b0, 11'(i)}, plane0_mirror[i]);
			write_loader({`TV_REGION_PLANE1, 1'b0, 11'(i)}, plane1_mirror[i]);
		end
		for (int i = 0; i < `TV_COLOR_WORDS; i++) begin
			data = 8'($urandom);
			color_mirror[i] = data[3:0];
			write_loader({`TV_REGION_COLOR, 8'(i)}, data);
		end
		@(posedge CLK_24M);
		dl_wr <= 1'b0;
		for (int i = 0; i < `TV_TILE_RAM_WORDS; i++) begin
			data = 8'($urandom);
			tile_mirror[i] = data;
			cpu_write(10'(i), data);
		end
	endtask

	// ------------------------------
	// Render control
	// ------------------------------

	task automatic start_render(input logic [7:0] line, input logic flp);
		@(posedge CLK_24M);
		exp_line = line;
		exp_flip = flp;
		pix_idx = 0;
		done_cnt = 0;
		render_start <= 1'b1;
		render_line  <= line;
		flip         <= flp;
		@(posedge CLK_24M);
		render_start <= 1'b0;
		// Busy one cycle after the request
		@(negedge CLK_24M);
		if (!busy) begin
			report_error("busy did not rise after render_start");
		end
	endtask

	task automatic wait_line_done(input string what, output logic ok);
		int cycles;
		cycles = 0;
		while ((done_cnt == 0) && (cycles < wait_limit)) begin
			@(posedge CLK_24M);
			cycles++;
		end
		ok = (done_cnt != 0);
		if (!ok) begin
			$display("Timeout: no line_done within %0d cycles in %s", wait_limit, what);
			timed_out = 1'b1;
		end
	endtask

	task automatic finish_render(input string what);
		logic ok;
		wait_line_done(what, ok);
		if (ok) begin
			// Let the pipeline settle and look for extra pixels or a second done
			repeat (4) @(posedge CLK_24M);
			@(negedge CLK_24M);
			if (pix_idx != line_pixels) begin
				report_error($sformatf("%s gave %0d pixels", what, pix_idx));
			end
			if (done_cnt != 1) begin
				report_error($sformatf("%s gave %0d line_done pulses", what, done_cnt));
			end
			if (busy) begin
				report_error($sformatf("busy still high after %s", what));
			end
		end
	endtask

	task automatic close_test(input string name, input int errs_before);
		if ((error_total() == errs_before) && !timed_out) begin
			pass_cnt++;
			$display("%s: passed", name);
		end else begin
			fail_cnt++;
			$display("%s: failed", name);
		end
	endtask

	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		while (!I_H_CNT && (cycles < 100)) begin
			@(posedge CLK_24M);
			cycles++;
		end
		if (!I_H_CNT) begin
			$display("Timeout: reset was never released");
			timed_out = 1'b1;
		end else begin
			@(negedge CLK_24M);
			if (busy || pix_valid || line_done) begin
				report_error("outputs not idle after reset");
			end
		end
	endtask

	// ------------------------------
	// Tests
	// ------------------------------

	task automatic run_readback();
		int errs_before;
		host_bus_pkg::cpu_addr_t addr;
		logic [7:0] data;
		logic [7:0] rd;
		errs_before = error_total();
		for (int i = 0; i < 24; i++) begin
			addr = 10'($urandom);
			data = 8'($urandom);
			cpu_write(addr, data);
			tile_mirror[addr] = data;
			cpu_read(addr, rd);
			if (rd !== data) begin
				report_error($sformatf("read-back of %03h gave %02h, expected %02h", addr, rd, data));
			end
		end
		close_test("cpu write and read-back", errs_before);
	endtask

	task automatic check_render_line(
		input string      name,
		input logic [7:0] line,
		input logic       flp,
		input logic       stalls
	);
		int errs_before;
		errs_before = error_total();
		stall_en = stalls;
		start_render(line, flp);
		finish_render(name);
		stall_en = 1'b0;
		close_test(name, errs_before);
	endtask

	task automatic check_busy_lockout();
		int errs_before;
		host_bus_pkg::cpu_addr_t addr;
		logic [7:0] old_data;
		logic [7:0] rd;
		errs_before = error_total();
		addr = 10'($urandom);
		old_data = tile_mirror[addr];
		start_render(8'($urandom), 1'b0);
		// Both accesses fall inside the line
		cpu_write(addr, ~old_data);
		cpu_read(addr, rd);
		if (rd !== 8'h00) begin
			report_error($sformatf("read while busy gave %02h, expected 00", rd));
		end
		finish_render("busy lockout render");
		cpu_read(addr, rd);
		if (rd !== old_data) begin
			report_error($sformatf("tile %03h holds %02h after busy write, expected %02h",
				addr, rd, old_data));
		end
		close_test("busy lockout", errs_before);
	endtask

	initial begin
		// Seed the generator once
		void'($urandom(29049));
		wait_for_reset();
		if (!timed_out) begin
			fill_memories();
			run_readback();
		end
		test_line = 8'($urandom);
		if (!timed_out) begin
			check_render_line("render flip low", test_line, 1'b0, 1'b0);
		end
		if (!timed_out) begin
			check_render_line("render flip high", test_line, 1'b1, 1'b0);
		end
		if (!timed_out) begin
			check_render_line("render with credit stalls", 8'($urandom), 1'($urandom), 1'b1);
		end
		if (!timed_out) begin
			check_busy_lockout();
		end
		$display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, error_total());
		if ((fail_cnt == 0) && (error_total() == 0) && !timed_out) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- testbench/tile_video_asserts.sv
`timescale 1ns/10ps
`include "tile_video_macros.svh"

module tile_video_asserts #(
	parameter int credit_w = $clog2(`TV_CREDITS + 1)
) (
	input logic                          CLK_24M,
	input logic                          I_H_CNT,
	input logic                          render_start,
	input logic                          busy,
	input logic                          credit_return,
	input logic                          pix_valid,
	input logic                          line_done,
	// Mixer credit count and fetcher FSM state
	input logic [credit_w-1:0]           credits,
	input video_types_pkg::fetch_state_t state
);

	// Lines accepted and not yet closed by line_done
	logic [1:0] open_lines;
	logic       start_ok;
	// Pixels seen on the port and not yet paid back
	int         sent_open;
	// Failed assertions so far
	int         assert_errs = 0;

	// Start only counts while the fetcher is idle
	assign start_ok = render_start && !busy;

	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT) begin
			open_lines <= '0;
			sent_open  <= 0;
		end else begin
			open_lines <= open_lines + (start_ok ? 2'd1 : 2'd0) - (line_done ? 2'd1 : 2'd0);
			sent_open  <= sent_open + (pix_valid ? 1 : 0) - (credit_return ? 1 : 0);
		end
	end

	// ------------------------------
	// Credit rules
	// ------------------------------

	// Never more credits than the mixer starts with
	credit_bound: assert property (@(posedge CLK_24M) disable iff (!I_H_CNT)
		credits <= credit_w'(`TV_CREDITS))
		else begin
			$error("credit count above its limit");
			assert_errs++;
		end

	// A new pixel needs room at the consumer, counted from the port
	valid_needs_credit: assert property (@(posedge CLK_24M) disable iff (!I_H_CNT)
		pix_valid |-> (sent_open < `TV_CREDITS))
		else begin
			$error("pix_valid raised with zero credits");
			assert_errs++;
		end

	// ------------------------------
	// Busy and line rules
	// ------------------------------

	// FSM idle and busy low when reset lets go
	idle_after_reset: assert property (@(posedge CLK_24M)
		$rose(I_H_CNT) |-> (!busy && (state == video_types_pkg::IDLE)))
		else begin
			$error("busy high coming out of reset");
			assert_errs++;
		end

	// Each line_done closes exactly one accepted render
	done_per_start: assert property (@(posedge CLK_24M) disable iff (!I_H_CNT)
		line_done |-> (open_lines == 2'd1))
		else begin
			$error("line_done without a matching render_start");
			assert_errs++;
		end

	// No second start while a line is still open
	start_when_closed: assert property (@(posedge CLK_24M) disable iff (!I_H_CNT)
		start_ok |-> ((open_lines == 2'd0) || line_done))
		else begin
			$error("render accepted while a line was still open");
			assert_errs++;
		end

endmodule

bind tile_video_top tile_video_asserts u_asserts (
	.CLK_24M       (CLK_24M),
	.I_H_CNT       (I_H_CNT),
	.render_start  (render_start),
	.busy          (busy),
	.credit_return (credit_return),
	.pix_valid     (pix_valid),
	.line_done     (line_done),
	.credits       (u_mixer.credits),
	.state         (u_fetcher.state)
);

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic CLK_24M,
	output logic I_H_CNT
);

	// 24M stand-in, 10 ns period
	initial begin
		CLK_24M = 1'b0;
		forever #5 CLK_24M = ~CLK_24M;
	end

	// Reset held low through the first 16 rising edges
	initial begin
		I_H_CNT = 1'b0;
		repeat (16) @(posedge CLK_24M);
		I_H_CNT <= 1'b1;
	end

endmodule

//--- logic/tile_video_top.sv
`timescale 1ns/10ps

module tile_video_top (
	input  logic                    CLK_24M,
	input  logic                    I_H_CNT,
	// CPU byte port
	input  host_bus_pkg::cpu_addr_t cpu_addr,
	input  logic [7:0]              cpu_wdata,
	input  logic                    cpu_we,
	input  logic                    cpu_re,
	output logic [7:0]              cpu_rdata,
	// Loader port
	input  logic [15:0]             dl_addr,
	input  logic                    dl_wr,
	input  logic [7:0]              dl_data,
	// Render control
	input  logic                    render_start,
	input  logic [7:0]              render_line,
	input  logic                    flip,
	output logic                    busy,
	// Pixel stream with credits
	input  logic                    credit_return,
	output logic                    pix_valid,
	output logic [3:0]              pix_color,
	output logic [1:0]              pix_value,
	output logic                    line_done
);

	// Fetcher to mixer
	logic       tile_valid;
	logic [3:0] tile_color;
	logic       line_last;
	// Shifters to mixer
	logic       plane0_bit;
	logic       plane1_bit;
	video_types_pkg::tile_pixel_t pix_data;

	tile_step_if u_step ();

	// ------------------------------
	// Fetch, two planes, mix
	// ------------------------------

	tile_fetcher u_fetcher (
		.CLK_24M      (CLK_24M),
		.I_H_CNT      (I_H_CNT),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_we       (cpu_we),
		.cpu_re       (cpu_re),
		.cpu_rdata    (cpu_rdata),
		.dl_addr      (dl_addr),
		.dl_wr        (dl_wr),
		.dl_data      (dl_data),
		.render_start (render_start),
		.render_line  (render_line),
		.flip         (flip),
		.busy         (busy),
		.step         (u_step),
		.tile_valid   (tile_valid),
		.tile_color   (tile_color),
		.line_last    (line_last)
	);

	// Low value bit
	plane_shifter #(.region(host_bus_pkg::PLANE0)) u_plane0 (
		.CLK_24M   (CLK_24M),
		.I_H_CNT   (I_H_CNT),
		.dl_addr   (dl_addr),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.step      (u_step),
		.plane_bit (plane0_bit)
	);

	// High value bit
	plane_shifter #(.region(host_bus_pkg::PLANE1)) u_plane1 (
		.CLK_24M   (CLK_24M),
		.I_H_CNT   (I_H_CNT),
		.dl_addr   (dl_addr),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.step      (u_step),
		.plane_bit (plane1_bit)
	);

	pixel_mixer u_mixer (
		.CLK_24M       (CLK_24M),
		.I_H_CNT       (I_H_CNT),
		.plane0_bit    (plane0_bit),
		.plane1_bit    (plane1_bit),
		.tile_valid    (tile_valid),
		.tile_color    (tile_color),
		.line_last     (line_last),
		.step          (u_step),
		.credit_return (credit_return),
		.pix_valid     (pix_valid),
		.pix_data      (pix_data),
		.line_done     (line_done)
	);

	// Pixel fields as plain ports
	assign pix_color = pix_data.color;
	assign pix_value = pix_data.value;

endmodule

//--- logic/pixel_mixer.sv
`timescale 1ns/10ps
`include "tile_video_macros.svh"

module pixel_mixer (
	input  logic                       CLK_24M,
	input  logic                       I_H_CNT,
	// Plane bits from the shifters
	input  logic                       plane0_bit,
	input  logic                       plane1_bit,
	// Tile context from the fetcher
	input  logic                       tile_valid,
	input  logic [3:0]                 tile_color,
	input  logic                       line_last,
	// Pixel pacing
	tile_step_if.mixer                 step,
	// Downstream
	input  logic                       credit_return,
	output logic                       pix_valid,
	output video_types_pkg::tile_pixel_t pix_data,
	output logic                       line_done
);

	localparam int credit_w = $clog2(`TV_CREDITS + 1);

	logic [credit_w-1:0] credits;
	logic                fire;
	logic [2:0]          last_cnt;
	logic                last_pix;

	// One pixel leaves per step while a tile is ready and credit remains
	assign fire         = tile_valid && (credits != '0);
	assign step.advance = fire;

	// ------------------------------
	// Credit counter
	// ------------------------------

	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT) begin
			credits <= credit_w'(`TV_CREDITS);
		end else begin
			case ({fire, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: begin
					// Saturate on a stray return
					if (credits != credit_w'(`TV_CREDITS)) begin
						credits <= credits + 1'b1;
					end
				end
				// Spend and return in one cycle cancel out
				default: credits <= credits;
			endcase
		end
	end

	// ------------------------------
	// Output stage
	// ------------------------------

	// Pixel payload
	always_ff @(posedge CLK_24M) begin
		if (fire) begin
			pix_data.color <= tile_color;
			pix_data.value <= {plane1_bit, plane0_bit};
		end
	end

	// Valid, end of line tracking
	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT) begin
			pix_valid <= 1'b0;
			last_cnt  <= '0;
			last_pix  <= 1'b0;
			line_done <= 1'b0;
		end else begin
			pix_valid <= fire;
			// Count pixels of the final tile only
			if (!line_last) begin
				last_cnt <= '0;
			end else if (fire) begin
				last_cnt <= last_cnt + 3'd1;
			end
			// Marks the cycle that carries the last pixel
			last_pix  <= fire && line_last && (last_cnt == 3'(`TV_PIX_PER_TILE - 1));
			// Done one cycle after that pixel
			line_done <= last_pix;
		end
	end

endmodule

//--- logic/plane_shifter.sv
`timescale 1ns/10ps
`include "tile_video_macros.svh"

module plane_shifter #(
	// PLANE0 or PLANE1
	parameter host_bus_pkg::load_region_t region = host_bus_pkg::PLANE0
) (
	input  logic         CLK_24M,
	input  logic         I_H_CNT,
	// Loader port
	input  logic [15:0]  dl_addr,
	input  logic         dl_wr,
	input  logic [7:0]   dl_data,
	// Tile step bus
	tile_step_if.shifter step,
	output logic         plane_bit
);

	// Only the two plane regions make sense here
	if ((region != host_bus_pkg::PLANE0) && (region != host_bus_pkg::PLANE1)) begin : g_bad_region
		$error("plane_shifter region must be PLANE0 or PLANE1");
	end

	// Bitplane ROM, 8 rows per tile code
	logic [7:0]  plane_rom [`TV_PLANE_ROM_WORDS];
	logic [10:0] rom_addr;
	logic [7:0]  rom_word;
	logic        rom_wr;
	logic [7:0]  shreg;

	// ------------------------------
	// Loader writes
	// ------------------------------

	assign rom_wr = dl_wr && (host_bus_pkg::decode_region(dl_addr) == region);

	always_ff @(posedge CLK_24M) begin
		if (rom_wr) begin
			plane_rom[dl_addr[10:0]] <= dl_data;
		end
	end

	// Code in the upper bits, row inside the tile in the lower
	assign rom_addr = {step.code, step.fine_row};
	assign rom_word = plane_rom[rom_addr];

	// ------------------------------
	// Shift register
	// ------------------------------

	// Load wins over advance, the fetcher never sends both
	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT) begin
			shreg <= '0;
		end else if (step.load) begin
			shreg <= rom_word;
		end else if (step.advance) begin
			// Mirrored line consumes the byte from bit 0 upward
			if (step.flip) begin
				shreg <= {1'b0, shreg[7:1]};
			end else begin
				shreg <= {shreg[6:0], 1'b0};
			end
		end
	end

	// Leftmost pixel is bit 7, bit 0 under flip
	assign plane_bit = step.flip ? shreg[0] : shreg[7];

endmodule

//--- logic/tile_fetcher.sv
`timescale 1ns/10ps
`include "tile_video_macros.svh"

module tile_fetcher (
	input  logic                    CLK_24M,
	input  logic                    I_H_CNT,
	// CPU byte port
	input  host_bus_pkg::cpu_addr_t cpu_addr,
	input  logic [7:0]              cpu_wdata,
	input  logic                    cpu_we,
	input  logic                    cpu_re,
	output logic [7:0]              cpu_rdata,
	// Loader port
	input  logic [15:0]             dl_addr,
	input  logic                    dl_wr,
	input  logic [7:0]              dl_data,
	// Render request
	input  logic                    render_start,
	input  logic [7:0]              render_line,
	input  logic                    flip,
	output logic                    busy,
	// To the shifters and the mixer
	tile_step_if.fetcher            step,
	output logic                    tile_valid,
	output logic [3:0]              tile_color,
	output logic                    line_last
);

	// Tile codes, 32 rows of 32
	logic [7:0] tile_ram [`TV_TILE_RAM_WORDS];
	// Color attribute, one per column per group of four tile rows
	logic [3:0] color_ram [`TV_COLOR_WORDS];

	video_types_pkg::fetch_state_t state;
	logic [7:0] line_q;
	logic       flip_q;
	logic [4:0] col_q;
	logic [2:0] adv_cnt;
	logic       last_col;
	logic       re_q;
	logic [7:0] ram_q;
	logic [3:0] color_q;
	logic [9:0] rd_addr;
	logic       color_wr;

	// CPU locked out for the whole line
	assign busy = (state != video_types_pkg::IDLE);

	// Shared read port
	// Render address while busy, CPU address otherwise
	assign rd_addr = busy ? {line_q[7:3], col_q} : cpu_addr;

	assign color_wr = dl_wr && (host_bus_pkg::decode_region(dl_addr) == host_bus_pkg::COLOR);

	// ------------------------------
	// Memories
	// ------------------------------

	always_ff @(posedge CLK_24M) begin
		if (cpu_we && !busy) begin
			tile_ram[cpu_addr] <= cpu_wdata;
		end
		ram_q <= tile_ram[rd_addr];
	end

	// Tile row group in the upper bits, column in the lower
	always_ff @(posedge CLK_24M) begin
		if (color_wr) begin
			color_ram[dl_addr[7:0]] <= dl_data[3:0];
		end
		color_q <= color_ram[{line_q[7:5], col_q}];
	end

	// Read strobe follows the data by one cycle
	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT) begin
			re_q <= 1'b0;
		end else begin
			re_q <= cpu_re && !busy;
		end
	end

	// Zero unless a read was accepted
	assign cpu_rdata = re_q ? ram_q : 8'h00;

	// ------------------------------
	// Render FSM
	// ------------------------------

	// Last column depends on walk direction
	assign last_col = (col_q == (flip_q ? 5'd0 : 5'(`TV_TILE_COLS - 1)));

	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT) begin
			state   <= video_types_pkg::IDLE;
			line_q  <= '0;
			flip_q  <= 1'b0;
			col_q   <= '0;
			adv_cnt <= '0;
		end else begin
			case (state)
				video_types_pkg::IDLE: begin
					if (render_start) begin
						line_q  <= render_line;
						flip_q  <= flip;
						// Mirrored line walks from the right edge
						col_q   <= flip ? 5'(`TV_TILE_COLS - 1) : 5'd0;
						adv_cnt <= '0;
						state   <= video_types_pkg::READ_CODE;
					end
				end
				video_types_pkg::READ_CODE: begin
					state <= video_types_pkg::LOAD_PLANES;
				end
				video_types_pkg::LOAD_PLANES: begin
					state <= video_types_pkg::SHIFT;
				end
				video_types_pkg::SHIFT: begin
					// Held here while the mixer has no credit
					if (step.advance) begin
						if (adv_cnt == 3'(`TV_PIX_PER_TILE - 1)) begin
							adv_cnt <= '0;
							if (last_col) begin
								state <= video_types_pkg::FINISH;
							end else begin
								col_q <= flip_q ? col_q - 5'd1 : col_q + 5'd1;
								state <= video_types_pkg::READ_CODE;
							end
						end else begin
							adv_cnt <= adv_cnt + 3'd1;
						end
					end
				end
				video_types_pkg::FINISH: begin
					state <= video_types_pkg::IDLE;
				end
				default: begin
					state <= video_types_pkg::IDLE;
				end
			endcase
		end
	end

	// Tile code sits in ram_q during LOAD_PLANES
	assign step.load     = (state == video_types_pkg::LOAD_PLANES);
	assign step.code     = ram_q;
	assign step.fine_row = line_q[2:0];
	assign step.flip     = flip_q;

	// Mixer side
	assign tile_valid = (state == video_types_pkg::SHIFT);
	assign tile_color = color_q;
	assign line_last  = tile_valid && last_col;

endmodule

//--- logic/tile_step_if.sv
`timescale 1ns/10ps

// Tile step bus
// Fetcher announces a new tile, mixer strobes one pixel at a time,
// both plane shifters follow in lock step
interface tile_step_if;

	// One-cycle pulse, new tile code present
	logic       load;
	// Tile code and row inside the tile
	logic [7:0] code;
	logic [2:0] fine_row;
	// Horizontal mirror for the whole line
	logic       flip;
	// One-cycle pulse, shift one pixel
	logic       advance;

	// Fetcher side
	modport fetcher (
		output load,
		output code,
		output fine_row,
		output flip,
		input  advance
	);

	// Mixer only paces the shifters
	modport mixer (
		output advance
	);

	// Plane shifters listen to everything
	modport shifter (
		input load,
		input code,
		input fine_row,
		input flip,
		input advance
	);

endinterface

//--- logic/host_bus_pkg.sv
package host_bus_pkg;

	`include "tile_video_macros.svh"

	// Tile RAM address from the CPU, 32 x 32 entries
	typedef logic [9:0] cpu_addr_t;

	// Targets of the loader port
	typedef enum logic [1:0] {
		NONE,
		PLANE0,
		PLANE1,
		COLOR
	} load_region_t;

	// Loader target from the upper address bits
	function automatic load_region_t decode_region(input logic [15:0] addr);
		if (addr[15:12] == `TV_REGION_PLANE0) return PLANE0;
		if (addr[15:12] == `TV_REGION_PLANE1) return PLANE1;
		if (addr[15:8] == `TV_REGION_COLOR) return COLOR;
		return NONE;
	endfunction

endpackage

//--- logic/video_types_pkg.sv
package video_types_pkg;

	// ------------------------------
	// Render side types
	// ------------------------------

	// Fetch FSM
	// IDLE waits for a render request
	// READ_CODE reads tile RAM and color table
	// LOAD_PLANES lets both plane ROMs load their shifters
	// SHIFT waits for eight advance strobes
	// FINISH is the single cycle after the last pixel is issued
	typedef enum logic [2:0] {
		IDLE,
		READ_CODE,
		LOAD_PLANES,
		SHIFT,
		FINISH
	} fetch_state_t;

	// One output pixel
	// Color from the attribute table, value from the two planes
	typedef struct packed {
		logic [3:0] color;
		logic [1:0] value;
	} tile_pixel_t;

endpackage

//--- logic/tile_video_macros.svh
`ifndef TILE_VIDEO_MACROS_SVH
`define TILE_VIDEO_MACROS_SVH

// ------------------------------
// Line and tile geometry
// ------------------------------

// Tile columns across one scan line
`define TV_TILE_COLS 32
// Pixels in one tile row
`define TV_PIX_PER_TILE 8

// Memory depths
`define TV_TILE_RAM_WORDS 1024
`define TV_PLANE_ROM_WORDS 2048
`define TV_COLOR_WORDS 256

// ------------------------------
// Loader address decode
// ------------------------------

// Upper nibble of the loader address for the bitplane ROMs
`define TV_REGION_PLANE0 4'h8
`define TV_REGION_PLANE1 4'h9
// Upper byte for the color attribute table
`define TV_REGION_COLOR 8'hF2

// Pixels the mixer may send before any credit comes back
`define TV_CREDITS 4

`endif
